//--- bench/tb_zip_debug.sv
// Testbench for the debug front end, driven line by line from the stimulus file.
// Runs AXI-lite writes and reads, waits, break and interrupt changes, and ready stalls.
`timescale 1ns/10ps
`include "dbg_macros.svh"

module tb_zip_debug;

	localparam int		HALF_PERIOD = 20;
	localparam int		DRIVE_DLY = 2;
	localparam int		NAME_W = 8 * 20;
	localparam dbg_pkg::axi_resp_t	RESP_OKAY = 2'b00;
	// Status word bits mirrored on top level outputs
	localparam int		STAT_RESET = 6;
	localparam int		STAT_HALTED = 9;

	logic			clk;
	logic			resetn;
	logic			cpu_reset, interrupt, brk;
	logic			awvalid, wvalid, bready, arvalid, rready;
	logic			awready, wready, bvalid, arready, rvalid;
	logic [`DBG_ADDR_W-1:0]	awaddr, araddr;
	logic [2:0]		prot;
	dbg_pkg::dbg_word_t	wdata, rdata;
	dbg_pkg::dbg_strb_t	wstrb;
	dbg_pkg::axi_resp_t	bresp, rresp;
	logic			cmd_reset, halted;

	// Stimulus table, one entry per operation
	logic [7:0]		op_q[$];
	logic [`DBG_ADDR_W-1:0]	addr_q[$];
	dbg_pkg::dbg_word_t	data_q[$];
	dbg_pkg::dbg_strb_t	strb_q[$];
	dbg_pkg::dbg_word_t	exp_q[$];
	logic [NAME_W-1:0]	name_q[$];

	logic			stall_en;
	int			cycles;
	int			limit;

	zip_debug_top #(.START_HALTED(1'b1)) u_zip_debug_top (
		.S_AXI_ACLK	(clk),
		.S_AXI_ARESETN	(resetn),
		.i_cpu_reset	(cpu_reset),
		.i_interrupt	(interrupt),
		.i_break	(brk),
		.i_dbg_awvalid	(awvalid),
		.o_dbg_awready	(awready),
		.i_dbg_awaddr	(awaddr),
		.i_dbg_awprot	(prot),
		.i_dbg_wvalid	(wvalid),
		.o_dbg_wready	(wready),
		.i_dbg_wdata	(wdata),
		.i_dbg_wstrb	(wstrb),
		.o_dbg_bvalid	(bvalid),
		.i_dbg_bready	(bready),
		.o_dbg_bresp	(bresp),
		.i_dbg_arvalid	(arvalid),
		.o_dbg_arready	(arready),
		.i_dbg_araddr	(araddr),
		.i_dbg_arprot	(prot),
		.o_dbg_rvalid	(rvalid),
		.i_dbg_rready	(rready),
		.o_dbg_rdata	(rdata),
		.o_dbg_rresp	(rresp),
		.o_cmd_reset	(cmd_reset),
		.o_halted	(halted)
	);

	// Handshake checks on the top level ports
	bind zip_debug_top zip_debug_chk u_zip_debug_chk (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.i_awvalid	(i_dbg_awvalid),
		.i_awready	(o_dbg_awready),
		.i_awaddr	(i_dbg_awaddr),
		.i_arvalid	(i_dbg_arvalid),
		.i_arready	(o_dbg_arready),
		.i_araddr	(i_dbg_araddr),
		.i_bvalid	(o_dbg_bvalid),
		.i_bready	(i_dbg_bready),
		.i_bresp	(o_dbg_bresp),
		.i_rvalid	(o_dbg_rvalid),
		.i_rready	(i_dbg_rready),
		.i_rdata	(o_dbg_rdata),
		.i_rresp	(o_dbg_rresp)
	);

	// 40 ns clock
	initial
	begin
		clk = 1'b0;
		forever
			#HALF_PERIOD clk = ~clk;
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	task automatic check_word(input logic [NAME_W-1:0] test,
		input dbg_pkg::dbg_word_t exp, input dbg_pkg::dbg_word_t act);
	begin
		if (act !== exp)
		begin
			$display("ERROR %0s: expected %08h, actual %08h", test, exp, act);
			$display("Test failures found");
			$fatal(1, "stopped at first data mismatch");
		end
	end
	endtask

	task automatic check_resp(input logic [NAME_W-1:0] test,
		input dbg_pkg::axi_resp_t exp, input dbg_pkg::axi_resp_t act);
	begin
		if (act !== exp)
		begin
			$display("ERROR %0s: expected resp %0d, actual resp %0d", test, exp, act);
			$display("Test failures found");
			$fatal(1, "stopped at first response mismatch");
		end
	end
	endtask

	task automatic check_level(input logic [NAME_W-1:0] test, input string sig,
		input logic exp, input logic act);
	begin
		if (act !== exp)
		begin
			$display("ERROR %0s: %0s expected %0b, actual %0b", test, sig, exp, act);
			$display("Test failures found");
			$fatal(1, "stopped at first level mismatch");
		end
	end
	endtask

	////////////////////////////////////////
	// Bus driving
	////////////////////////////////////////

	// Drive point, just past the rising edge
	task automatic next_drive();
	begin
		@(posedge clk);
		#DRIVE_DLY;
	end
	endtask

	// Random idle cycles before a VALID, only in stall mode
	task automatic idle_gap();
	int n;
	begin
		n = stall_en ? $urandom_range(0, 2) : 0;
		repeat (n)
			next_drive();
	end
	endtask

	// READY held low about a third of the time in stall mode
	function automatic logic draw_ready();
		return !stall_en || ($urandom_range(0, 2) != 0);
	endfunction

	task automatic write_access(input logic [`DBG_ADDR_W-1:0] addr,
		input dbg_pkg::dbg_word_t data, input dbg_pkg::dbg_strb_t strb,
		output dbg_pkg::axi_resp_t resp);
	logic aw_hs;
	logic w_hs;
	logic b_hs;
	begin
		idle_gap();
		awvalid = 1'b1;
		awaddr  = addr;
		wvalid  = 1'b1;
		wdata   = data;
		wstrb   = strb;
		// AW and W may be taken on different edges
		while (awvalid || wvalid)
		begin
			@(negedge clk);
			aw_hs = awvalid && awready;
			w_hs  = wvalid && wready;
			next_drive();
			if (aw_hs)
				awvalid = 1'b0;
			if (w_hs)
				wvalid = 1'b0;
		end
		b_hs = 1'b0;
		while (!b_hs)
		begin
			bready = draw_ready();
			@(negedge clk);
			b_hs = bvalid && bready;
			resp = bresp;
			next_drive();
		end
		bready = 1'b0;
	end
	endtask

	task automatic read_access(input logic [`DBG_ADDR_W-1:0] addr,
		output dbg_pkg::dbg_word_t data, output dbg_pkg::axi_resp_t resp);
	logic ar_hs;
	logic r_hs;
	begin
		idle_gap();
		arvalid = 1'b1;
		araddr  = addr;
		while (arvalid)
		begin
			@(negedge clk);
			ar_hs = arvalid && arready;
			next_drive();
			if (ar_hs)
				arvalid = 1'b0;
		end
		r_hs = 1'b0;
		while (!r_hs)
		begin
			rready = draw_ready();
			@(negedge clk);
			r_hs = rvalid && rready;
			data = rdata;
			resp = rresp;
			next_drive();
		end
		rready = 1'b0;
	end
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	task automatic load_stim();
	int			fd;
	int			n;
	string			line;
	logic [7:0]		op;
	logic [`DBG_ADDR_W-1:0]	addr;
	dbg_pkg::dbg_word_t	data, exp;
	dbg_pkg::dbg_strb_t	strb;
	logic [NAME_W-1:0]	name;
	begin
		fd = $fopen("bench/zip_debug_stim.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the stimulus file bench/zip_debug_stim.txt");
			$display("Test failures found");
			$fatal(1, "no stimulus");
		end
		else
		begin
			while (!$feof(fd))
			begin
				n = $fgets(line, fd);
				// Skip blank and comment lines
				if (n > 1 && line[0] != "#")
				begin
					n = $sscanf(line, "%c %h %h %h %h %s", op, addr, data, strb, exp, name);
					if (n != 6)
					begin
						$display("Stimulus line could not be parsed: %0s", line);
						$display("Test failures found");
						$fatal(1, "bad stimulus");
					end
					else
					begin
						op_q.push_back(op);
						addr_q.push_back(addr);
						data_q.push_back(data);
						strb_q.push_back(strb);
						exp_q.push_back(exp);
						name_q.push_back(name);
					end
				end
			end
			$fclose(fd);
		end
	end
	endtask

	// W write, R read, N wait, B break pulse, I interrupt level, S stall mode
	task automatic run_op(input int i);
	dbg_pkg::dbg_word_t	rd;
	dbg_pkg::axi_resp_t	resp;
	begin
		case (op_q[i])
		"W":
		begin
			write_access(addr_q[i], data_q[i], strb_q[i], resp);
			check_resp(name_q[i], exp_q[i][1:0], resp);
		end
		"R":
		begin
			read_access(addr_q[i], rd, resp);
			check_resp(name_q[i], RESP_OKAY, resp);
			check_word(name_q[i], exp_q[i], rd);
			// Status reads also pin the halted and reset outputs
			if (!addr_q[i][`REG_SEL_BIT + `DBG_LSB])
			begin
				check_level(name_q[i], "halted", exp_q[i][STAT_HALTED], halted);
				check_level(name_q[i], "cmd_reset", exp_q[i][STAT_RESET], cmd_reset);
			end
		end
		"N":
			repeat (data_q[i])
				next_drive();
		"B":
		begin
			brk = 1'b1;
			next_drive();
			brk = 1'b0;
		end
		"I":
			interrupt = data_q[i][0];
		"S":
			stall_en = data_q[i][0];
		default:
		begin
			$display("Unknown operation code on stimulus entry %0d", i);
			$display("Test failures found");
			$fatal(1, "bad operation");
		end
		endcase
	end
	endtask

	// Watchdog, limit scales with the stimulus length
	initial
	begin
		cycles = 0;
		wait (limit != 0);
		while (cycles < limit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("Test failures found");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		resetn    = 1'b0;
		cpu_reset = 1'b0;
		interrupt = 1'b0;
		brk       = 1'b0;
		awvalid   = 1'b0;
		awaddr    = '0;
		wvalid    = 1'b0;
		wdata     = '0;
		wstrb     = '0;
		bready    = 1'b0;
		arvalid   = 1'b0;
		araddr    = '0;
		rready    = 1'b0;
		prot      = 3'b000;
		stall_en  = 1'b0;
		limit     = 0;
		void'($urandom(32'hb83b991a));
		load_stim();
		limit = 64 * op_q.size();
		// Reset for 4 cycles
		repeat (4)
			@(posedge clk);
		#DRIVE_DLY;
		resetn = 1'b1;
		for (int i = 0; i < op_q.size(); i++)
			run_op(i);
		$display("All tests passed!");
		$finish;
	end

endmodule

//--- bench/zip_debug_chk.sv
// Handshake assertions for the debug AXI-lite port.
// Bound into the top level from the testbench.
`timescale 1ns/10ps

module zip_debug_chk (
	input  logic		S_AXI_ACLK,
	input  logic		S_AXI_ARESETN,
	input  logic		i_awvalid,
	input  logic		i_awready,
	input  logic [7:0]	i_awaddr,
	input  logic		i_arvalid,
	input  logic		i_arready,
	input  logic [7:0]	i_araddr,
	input  logic		i_bvalid,
	input  logic		i_bready,
	input  logic [1:0]	i_bresp,
	input  logic		i_rvalid,
	input  logic		i_rready,
	input  logic [31:0]	i_rdata,
	input  logic [1:0]	i_rresp
);

	////////////////////////////////////////
	// Master side held until taken
	////////////////////////////////////////

	aw_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr))
		else $error("AW dropped or changed before AWREADY");

	ar_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
		else $error("AR dropped or changed before ARREADY");

	////////////////////////////////////////
	// Slave responses
	////////////////////////////////////////

	b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
		else $error("B dropped or changed before BREADY");

	// Data and code both frozen under back-pressure
	r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata) && $stable(i_rresp))
		else $error("R dropped or changed before RREADY");

	// No response straight out of reset
	idle_after_reset: assert property (@(posedge S_AXI_ACLK)
		!S_AXI_ARESETN |=> !i_bvalid && !i_rvalid)
		else $error("BVALID or RVALID high after reset");

endmodule

//--- bench/zip_debug_stim.txt
# op addr data strb expect name, hex fields; W write, R read, N wait data cycles
# B break pulse, I interrupt level from data, S random stall mode from data
N 00 0000000c 0 00000000 boot_wait
R 00 00000000 0 00000600 boot_status
W 04 12345678 f 00000000 wr_r1
W 08 cafef00d f 00000000 wr_r2
W 7c a5a55a5a f 00000000 wr_r31
W 04 0badbeef f 00000000 rewr_r1
W 08 ffffffff 0 00000000 zero_strb_r2
R 84 00000000 0 0badbeef rd_r1
R 88 00000000 0 cafef00d rd_r2
R fc 00000000 0 a5a55a5a rd_r31
W 80 00000000 f 00000000 release
N 00 00000002 0 00000000 release_settle
R 00 00000000 0 00000000 run_status
W 80 00000400 f 00000000 halt
N 00 00000002 0 00000000 halt_settle
R 00 00000000 0 00000600 halt_status
W 80 00000000 f 00000000 release2
W 14 55aa1234 f 00000000 wr_r5_running
N 00 00000002 0 00000000 wr_settle
R 00 00000000 0 00000600 wr_halts
R 94 00000000 0 55aa1234 rd_r5
W 80 00000100 f 00000000 step
N 00 00000004 0 00000000 step_settle
R 00 00000000 0 00000600 step_status
W 80 00000040 1 00000000 reset_cmd
N 00 00000002 0 00000000 reset_settle
R 00 00000000 0 00000440 reset_hold
N 00 0000000e 0 00000000 reset_wait
R 00 00000000 0 00000600 reset_done
W 80 00000000 f 00000000 release3
B 00 00000000 0 00000000 break_pulse
N 00 00000002 0 00000000 break_settle
R 00 00000000 0 00008600 break_status
I 00 00000001 0 00000000 irq_on
R 00 00000000 0 00018680 irq_status
I 00 00000000 0 00000000 irq_off
S 00 00000001 0 00000000 stall_on
W 1c 77770007 f 00000000 wr_r7
W 20 88880008 f 00000000 wr_r8
R 9c 00000000 0 77770007 rd_r7
R a0 00000000 0 88880008 rd_r8
R 84 00000000 0 0badbeef rd_r1_again
R 00 00000000 0 00008600 stall_status

//--- design/cpu_run_ctrl.sv
// Run control: reset hold, halt and step commands, and the status word.
// Commands arrive as one-cycle strobes from the debug slave.
`timescale 1ns/10ps
`include "dbg_macros.svh"

module cpu_run_ctrl #(
	parameter bit START_HALTED = 1'b0
) (
	input  logic			S_AXI_ACLK,
	input  logic			S_AXI_ARESETN,
	input  logic			i_cpu_reset,
	input  logic			i_break,
	input  logic			i_interrupt,
	input  logic			i_cmd_we,
	input  dbg_pkg::dbg_word_t	i_cmd_data,
	input  dbg_pkg::dbg_strb_t	i_cmd_strb,
	input  logic			i_reg_wr_accept,
	input  logic			i_halted,
	output logic			o_cmd_reset,
	output logic			o_cmd_halt,
	output logic			o_cmd_step,
	output dbg_pkg::dbg_word_t	o_status
);

	localparam int CNT_W = $clog2(`RESET_DURATION + 1);

	logic [CNT_W-1:0]	hold_cnt;
	logic			reset_hold;
	logic			restart;
	logic			reset_wr, halt_wr, release_wr, step_wr;
	logic			break_seen;

	// Command decode, reset in byte 0, halt and step in byte 1
	assign reset_wr   = i_cmd_we && i_cmd_strb[0] && i_cmd_data[`RESET_BIT];
	assign step_wr    = i_cmd_we && i_cmd_strb[1] && i_cmd_data[`STEP_BIT];
	assign halt_wr    = i_cmd_we && i_cmd_strb[1] && i_cmd_data[`HALT_BIT]
		&& !i_cmd_data[`STEP_BIT];
	assign release_wr = i_cmd_we && i_cmd_strb[1]
		&& (!i_cmd_data[`HALT_BIT] || i_cmd_data[`STEP_BIT]);

	// Restarts the hold window
	assign restart = i_cpu_reset || reset_wr;

	////////////////////////////////////////
	// Reset hold
	////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || restart)
		begin
			hold_cnt   <= CNT_W'(`RESET_DURATION);
			reset_hold <= 1'b1;
		end
		else
		begin
			if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
			reset_hold <= (hold_cnt > 1);
		end
	end

	// Break resets instead of halting when starting free-running
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || restart || reset_hold)
			o_cmd_reset <= 1'b1;
		else
			o_cmd_reset <= i_break && !START_HALTED;
	end

	////////////////////////////////////////
	// Halt and step
	////////////////////////////////////////

	// Later lines win
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			o_cmd_halt <= START_HALTED;
		else if (o_cmd_reset && START_HALTED)
			o_cmd_halt <= 1'b1;
		else
		begin
			if (release_wr)
				o_cmd_halt <= 1'b0;
			if (i_break && START_HALTED)
				o_cmd_halt <= 1'b1;
			if (halt_wr)
				o_cmd_halt <= 1'b1;
			// Register writes need a stopped CPU
			if (i_reg_wr_accept)
				o_cmd_halt <= 1'b1;
			// Back to halt after a single step
			if (o_cmd_step)
				o_cmd_halt <= 1'b1;
		end
	end

	// Single-cycle step pulse
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			o_cmd_step <= 1'b0;
		else
			o_cmd_step <= step_wr;
	end

	// Sticky until the CPU is released again
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			break_seen <= 1'b0;
		else if (i_break)
			break_seen <= 1'b1;
		else if (release_wr)
			break_seen <= 1'b0;
	end

	// Status: 16 int, 15 break, 10 halt cmd, 9 halted, 7 int, 6 reset
	assign o_status = {15'h0, i_interrupt, break_seen, 3'b000, 1'b0,
		o_cmd_halt, i_halted, 1'b0, i_interrupt, o_cmd_reset, 6'h0};

endmodule

//--- design/dbg_axil_slave.sv
// AXI-lite debug slave: splits accesses into register and control spaces.
// Drives register file writes, command strobes and B/R responses.
`timescale 1ns/10ps
`include "dbg_macros.svh"

module dbg_axil_slave (
	input  logic			S_AXI_ACLK,
	input  logic			S_AXI_ARESETN,
	// Write address and data
	input  logic			i_dbg_awvalid,
	output logic			o_dbg_awready,
	input  dbg_pkg::dbg_waddr_t	i_dbg_awaddr,
	input  logic			i_dbg_wvalid,
	output logic			o_dbg_wready,
	input  dbg_pkg::dbg_word_t	i_dbg_wdata,
	input  dbg_pkg::dbg_strb_t	i_dbg_wstrb,
	// Write response
	output logic			o_dbg_bvalid,
	input  logic			i_dbg_bready,
	output dbg_pkg::axi_resp_t	o_dbg_bresp,
	// Read address and data
	input  logic			i_dbg_arvalid,
	output logic			o_dbg_arready,
	input  dbg_pkg::dbg_waddr_t	i_dbg_araddr,
	output logic			o_dbg_rvalid,
	input  logic			i_dbg_rready,
	output dbg_pkg::dbg_word_t	o_dbg_rdata,
	output dbg_pkg::axi_resp_t	o_dbg_rresp,
	// Register file side
	input  logic			i_wr_stall,
	output logic			o_reg_we,
	output dbg_pkg::reg_id_t	o_reg_wid,
	output dbg_pkg::dbg_word_t	o_reg_wdata,
	output dbg_pkg::reg_id_t	o_reg_rid,
	input  dbg_pkg::dbg_word_t	i_reg_rdata,
	// Run control side
	output logic			o_cmd_we,
	output dbg_pkg::dbg_word_t	o_cmd_data,
	output dbg_pkg::dbg_strb_t	o_cmd_strb,
	output logic			o_reg_wr_accept,
	input  dbg_pkg::dbg_word_t	i_status
);

	localparam dbg_pkg::axi_resp_t RESP_OKAY = 2'b00;

	logic			aw_valid, w_valid, ar_valid;
	dbg_pkg::dbg_waddr_t	aw_addr, ar_addr;
	dbg_pkg::dbg_word_t	w_data;
	dbg_pkg::dbg_strb_t	w_strb;
	logic			write_ready, read_ready;
	logic			aw_is_reg, ar_is_reg;
	logic			read_pending;

	////////////////////////////////////////
	// Write path
	////////////////////////////////////////

	skid_buffer #(.DW($bits(dbg_pkg::dbg_waddr_t))) u_aw_skid (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.i_valid	(i_dbg_awvalid),
		.o_ready	(o_dbg_awready),
		.i_data		(i_dbg_awaddr),
		.o_valid	(aw_valid),
		.i_ready	(write_ready),
		.o_data		(aw_addr)
	);

	// Data and strobe share one buffer
	skid_buffer #(.DW($bits(dbg_pkg::dbg_word_t) + $bits(dbg_pkg::dbg_strb_t))) u_w_skid (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.i_valid	(i_dbg_wvalid),
		.o_ready	(o_dbg_wready),
		.i_data		({i_dbg_wdata, i_dbg_wstrb}),
		.o_valid	(w_valid),
		.i_ready	(write_ready),
		.o_data		({w_data, w_strb})
	);

	// Low half of the map is the register space for writes
	assign aw_is_reg = !aw_addr[`REG_SEL_BIT];

	// Need both halves, a free B slot, and no stalled register write
	// unless this access never touches the register file
	assign write_ready = aw_valid && w_valid
		&& (!aw_is_reg || (w_strb == '0) || !i_wr_stall)
		&& (!o_dbg_bvalid || i_dbg_bready);

	assign o_cmd_we        = write_ready && !aw_is_reg;
	assign o_cmd_data      = w_data;
	assign o_cmd_strb      = w_strb;
	assign o_reg_wr_accept = write_ready && aw_is_reg && (w_strb != '0);

	// Pending register write, frozen while the file stalls
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_reg_we <= 1'b0;
		else if (!i_wr_stall)
			o_reg_we <= o_reg_wr_accept;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!i_wr_stall)
		begin
			o_reg_wid   <= dbg_pkg::reg_id_t'(aw_addr[`REG_SEL_BIT-1:0]);
			o_reg_wdata <= w_data;
		end
	end

	// One B per accepted write
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_dbg_bvalid <= 1'b0;
		else if (write_ready)
			o_dbg_bvalid <= 1'b1;
		else if (i_dbg_bready)
			o_dbg_bvalid <= 1'b0;
	end

	assign o_dbg_bresp = RESP_OKAY;

	////////////////////////////////////////
	// Read path
	////////////////////////////////////////

	skid_buffer #(.DW($bits(dbg_pkg::dbg_waddr_t))) u_ar_skid (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.i_valid	(i_dbg_arvalid),
		.o_ready	(o_dbg_arready),
		.i_data		(i_dbg_araddr),
		.o_valid	(ar_valid),
		.i_ready	(read_ready),
		.o_data		(ar_addr)
	);

	// Reads map the other way round
	assign ar_is_reg = ar_addr[`REG_SEL_BIT];

	// No new read while a register read waits for its data
	assign read_ready = ar_valid && !read_pending
		&& (!o_dbg_rvalid || i_dbg_rready);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			read_pending <= 1'b0;
		else
			read_pending <= read_ready && ar_is_reg;
	end

	// Index held for the extra cycle of a register read
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (read_ready)
			o_reg_rid <= dbg_pkg::reg_id_t'(ar_addr[`REG_SEL_BIT-1:0]);
	end

	// Status answers next cycle, registers one later
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_dbg_rvalid <= 1'b0;
		else if (!o_dbg_rvalid || i_dbg_rready)
			o_dbg_rvalid <= (read_ready && !ar_is_reg) || read_pending;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_dbg_rvalid || i_dbg_rready)
			o_dbg_rdata <= read_pending ? i_reg_rdata : i_status;
	end

	assign o_dbg_rresp = RESP_OKAY;

endmodule

//--- design/dbg_macros.svh
// Debug address map, command bit positions and reset hold length.
// Include wherever the debug map or command decode is needed.
`ifndef DBG_MACROS_SVH
`define DBG_MACROS_SVH

// Debug byte address width and dropped byte-offset bits
`define DBG_ADDR_W	8
`define DBG_LSB		2

// Word address bit picking the register space
`define REG_SEL_BIT	5

// Command word bit positions
`define RESET_BIT	6
`define STEP_BIT	8
`define HALT_BIT	10

// Cycles the CPU is held in reset
`define RESET_DURATION	10

`endif

//--- design/dbg_pkg.sv
// Shared vector types of the debug front end.
// Referenced by scoped name from the slave, run control and register file.
`include "dbg_macros.svh"

package dbg_pkg;

	// One debug data word
	typedef logic [31:0] dbg_word_t;

	// Byte write strobe
	typedef logic [3:0] dbg_strb_t;

	// Debug word address, byte offset removed
	typedef logic [`DBG_ADDR_W-`DBG_LSB-1:0] dbg_waddr_t;

	// CPU register index
	typedef logic [4:0] reg_id_t;

	// AXI response code
	typedef logic [1:0] axi_resp_t;

endpackage

//--- design/halted_regfile.sv
// Stand-in for the CPU core: 32 registers plus the halted state.
// Debug writes land only while halted, reads are combinational.
`timescale 1ns/10ps

module halted_regfile (
	input  logic			S_AXI_ACLK,
	input  logic			S_AXI_ARESETN,
	input  logic			i_cmd_reset,
	input  logic			i_cmd_halt,
	input  logic			i_cmd_step,
	input  logic			i_we,
	input  dbg_pkg::reg_id_t	i_wid,
	input  dbg_pkg::dbg_word_t	i_wdata,
	input  dbg_pkg::reg_id_t	i_rid,
	output dbg_pkg::dbg_word_t	o_rdata,
	output logic			o_halted,
	output logic			o_wr_stall
);

	// One entry per register index
	dbg_pkg::dbg_word_t regs [2**$bits(dbg_pkg::reg_id_t)];

	// Halt lags the command by one cycle
	// a step or a reset lets the core run
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_halted <= 1'b0;
		else
			o_halted <= i_cmd_halt && !i_cmd_step && !i_cmd_reset;
	end

	// Hold the pending write until the core stops
	assign o_wr_stall = i_we && !o_halted;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_we && o_halted)
			regs[i_wid] <= i_wdata;
	end

	assign o_rdata = regs[i_rid];

endmodule

//--- design/skid_buffer.sv
// One-deep skid buffer for a VALID/READY channel.
// Keeps upstream READY registered while downstream may stall.
`timescale 1ns/10ps

module skid_buffer #(
	parameter int DW = 8
) (
	input  logic		S_AXI_ACLK,
	input  logic		S_AXI_ARESETN,
	input  logic		i_valid,
	output logic		o_ready,
	input  logic [DW-1:0]	i_data,
	output logic		o_valid,
	input  logic		i_ready,
	output logic [DW-1:0]	o_data
);

	// Held item, in use while downstream stalls
	logic		r_valid;
	logic [DW-1:0]	r_data;

	// Ready only while the spare slot is empty
	assign o_ready = !r_valid;

	// Held item goes first
	assign o_valid = i_valid || r_valid;
	assign o_data  = r_valid ? r_data : i_data;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && !i_ready)
			// Accepted but not passed on
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Capture whatever is offered while the slot is free
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_data;
	end

endmodule

//--- design/zip_debug_top.sv
// Debug front end top: AXI-lite slave, run control and register file model.
// START_HALTED picks halt or reset on an exception break.
`timescale 1ns/10ps
`include "dbg_macros.svh"

module zip_debug_top #(
	parameter bit START_HALTED = 1'b0
) (
	input  logic				S_AXI_ACLK,
	input  logic				S_AXI_ARESETN,
	input  logic				i_cpu_reset,
	input  logic				i_interrupt,
	input  logic				i_break,
	// Debug AXI-lite, PROT is ignored
	input  logic				i_dbg_awvalid,
	output logic				o_dbg_awready,
	input  logic [`DBG_ADDR_W-1:0]		i_dbg_awaddr,
	input  logic [2:0]			i_dbg_awprot,
	input  logic				i_dbg_wvalid,
	output logic				o_dbg_wready,
	input  dbg_pkg::dbg_word_t		i_dbg_wdata,
	input  dbg_pkg::dbg_strb_t		i_dbg_wstrb,
	output logic				o_dbg_bvalid,
	input  logic				i_dbg_bready,
	output dbg_pkg::axi_resp_t		o_dbg_bresp,
	input  logic				i_dbg_arvalid,
	output logic				o_dbg_arready,
	input  logic [`DBG_ADDR_W-1:0]		i_dbg_araddr,
	input  logic [2:0]			i_dbg_arprot,
	output logic				o_dbg_rvalid,
	input  logic				i_dbg_rready,
	output dbg_pkg::dbg_word_t		o_dbg_rdata,
	output dbg_pkg::axi_resp_t		o_dbg_rresp,
	output logic				o_cmd_reset,
	output logic				o_halted
);

	// Word addresses, byte offset dropped
	dbg_pkg::dbg_waddr_t	aw_word, ar_word;
	// Slave to register file
	logic			reg_we, wr_stall;
	dbg_pkg::reg_id_t	reg_wid, reg_rid;
	dbg_pkg::dbg_word_t	reg_wdata, reg_rdata;
	// Slave to run control
	logic			cmd_we, reg_wr_accept;
	dbg_pkg::dbg_word_t	cmd_data, status;
	dbg_pkg::dbg_strb_t	cmd_strb;
	// Run control to register file
	logic			cmd_halt, cmd_step;

	assign aw_word = i_dbg_awaddr[`DBG_ADDR_W-1:`DBG_LSB];
	assign ar_word = i_dbg_araddr[`DBG_ADDR_W-1:`DBG_LSB];

	dbg_axil_slave u_dbg_axil_slave (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.i_dbg_awvalid	(i_dbg_awvalid),
		.o_dbg_awready	(o_dbg_awready),
		.i_dbg_awaddr	(aw_word),
		.i_dbg_wvalid	(i_dbg_wvalid),
		.o_dbg_wready	(o_dbg_wready),
		.i_dbg_wdata	(i_dbg_wdata),
		.i_dbg_wstrb	(i_dbg_wstrb),
		.o_dbg_bvalid	(o_dbg_bvalid),
		.i_dbg_bready	(i_dbg_bready),
		.o_dbg_bresp	(o_dbg_bresp),
		.i_dbg_arvalid	(i_dbg_arvalid),
		.o_dbg_arready	(o_dbg_arready),
		.i_dbg_araddr	(ar_word),
		.o_dbg_rvalid	(o_dbg_rvalid),
		.i_dbg_rready	(i_dbg_rready),
		.o_dbg_rdata	(o_dbg_rdata),
		.o_dbg_rresp	(o_dbg_rresp),
		.i_wr_stall	(wr_stall),
		.o_reg_we	(reg_we),
		.o_reg_wid	(reg_wid),
		.o_reg_wdata	(reg_wdata),
		.o_reg_rid	(reg_rid),
		.i_reg_rdata	(reg_rdata),
		.o_cmd_we	(cmd_we),
		.o_cmd_data	(cmd_data),
		.o_cmd_strb	(cmd_strb),
		.o_reg_wr_accept(reg_wr_accept),
		.i_status	(status)
	);

	cpu_run_ctrl #(.START_HALTED(START_HALTED)) u_cpu_run_ctrl (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.i_cpu_reset	(i_cpu_reset),
		.i_break	(i_break),
		.i_interrupt	(i_interrupt),
		.i_cmd_we	(cmd_we),
		.i_cmd_data	(cmd_data),
		.i_cmd_strb	(cmd_strb),
		.i_reg_wr_accept(reg_wr_accept),
		.i_halted	(o_halted),
		.o_cmd_reset	(o_cmd_reset),
		.o_cmd_halt	(cmd_halt),
		.o_cmd_step	(cmd_step),
		.o_status	(status)
	);

	halted_regfile u_halted_regfile (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.i_cmd_reset	(o_cmd_reset),
		.i_cmd_halt	(cmd_halt),
		.i_cmd_step	(cmd_step),
		.i_we		(reg_we),
		.i_wid		(reg_wid),
		.i_wdata	(reg_wdata),
		.i_rid		(reg_rid),
		.o_rdata	(reg_rdata),
		.o_halted	(o_halted),
		.o_wr_stall	(wr_stall)
	);

endmodule

//--- list.f
+incdir+design
design/dbg_pkg.sv
design/skid_buffer.sv
design/dbg_axil_slave.sv
design/cpu_run_ctrl.sv
design/halted_regfile.sv
design/zip_debug_top.sv
bench/zip_debug_chk.sv
bench/tb_zip_debug.sv

//--- run.sh
#!/bin/sh
# Build and run the debug front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_zip_debug -f list.f -o sim_tb_zip_debug
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb_zip_debug)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qxF "All tests passed!"; then
	exit 0
else
	exit 1
fi
